// ==== design/deca_pkg.sv ====
package deca_pkg;

  // bus widths
  // byte address width, the bus itself carries word addresses
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  localparam int WB_SW = WB_DW / 8;

  // request from the bus master
  typedef struct packed {
    // word address, byte address bits 31:2
    logic [WB_AW-3:0] adr;
    logic [WB_DW-1:0] dat;
    logic [WB_SW-1:0] sel;
    logic             we;
    logic             cyc;
    logic             stb;
  } wb_req_t;

  // response back to the master
  typedef struct packed {
    logic [WB_DW-1:0] dat;
    logic             ack;
  } wb_rsp_t;

  // peripheral regions, byte address bits 7:4
  typedef enum logic [2:0] {
    SLOT_GPIO_A = 3'd0,
    SLOT_GPIO_B = 3'd1,
    SLOT_BOARD  = 3'd2,
    SLOT_TIMER  = 3'd3,
    SLOT_NONE   = 3'd4
  } slot_e;

  // register offsets, byte address bits 3:2
  typedef enum logic [1:0] {
    GPIO_DATA = 2'd0,
    GPIO_DIR  = 2'd1
  } gpio_reg_e;

  typedef enum logic [1:0] {
    BOARD_LEDS = 2'd0,
    BOARD_SW   = 2'd1,
    BOARD_PEND = 2'd2,
    BOARD_MASK = 2'd3
  } board_reg_e;

  typedef enum logic [1:0] {
    TIM_LO = 2'd0,
    TIM_HI = 2'd1,
    CMP_LO = 2'd2,
    CMP_HI = 2'd3
  } timer_reg_e;

  // one gpio bank at its pins, dir bit set means drive
  typedef struct packed {
    logic [7:0] dout;
    logic [7:0] dir;
  } gpio_pins_t;

endpackage

// ==== design/wb_decoder.sv ====
`timescale 1ns/10ps

module wb_decoder (
  input  logic              i_clk,
  input  logic              i_rst,
  input  deca_pkg::wb_req_t host_req_i,
  output deca_pkg::wb_rsp_t host_rsp_o,
  output deca_pkg::wb_req_t gpio_a_req_o,
  output deca_pkg::wb_req_t gpio_b_req_o,
  output deca_pkg::wb_req_t board_req_o,
  output deca_pkg::wb_req_t timer_req_o,
  input  deca_pkg::wb_rsp_t gpio_a_rsp_i,
  input  deca_pkg::wb_rsp_t gpio_b_rsp_i,
  input  deca_pkg::wb_rsp_t board_rsp_i,
  input  deca_pkg::wb_rsp_t timer_rsp_i
);

  import deca_pkg::*;

  slot_e slot;
  logic  none_ack_q;

  // word address bits 5:2 are byte address bits 7:4
  always_comb begin
    case (host_req_i.adr[5:2])
      4'd0:    slot = SLOT_GPIO_A;
      4'd1:    slot = SLOT_GPIO_B;
      4'd2:    slot = SLOT_BOARD;
      4'd3:    slot = SLOT_TIMER;
      default: slot = SLOT_NONE;
    endcase
  end

  // same request to every slave, only the selected one sees stb
  always_comb begin
    gpio_a_req_o     = host_req_i;
    gpio_b_req_o     = host_req_i;
    board_req_o      = host_req_i;
    timer_req_o      = host_req_i;
    gpio_a_req_o.stb = host_req_i.stb && (slot == SLOT_GPIO_A);
    gpio_b_req_o.stb = host_req_i.stb && (slot == SLOT_GPIO_B);
    board_req_o.stb  = host_req_i.stb && (slot == SLOT_BOARD);
    timer_req_o.stb  = host_req_i.stb && (slot == SLOT_TIMER);
  end

  // unmapped region answers by itself, one cycle later
  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      none_ack_q <= 1'b0;
    end else begin
      none_ack_q <= host_req_i.cyc && host_req_i.stb && (slot == SLOT_NONE) && !none_ack_q;
    end
  end

  // master holds the request through the ack cycle, so slot still points at the responder
  always_comb begin
    case (slot)
      SLOT_GPIO_A: host_rsp_o = gpio_a_rsp_i;
      SLOT_GPIO_B: host_rsp_o = gpio_b_rsp_i;
      SLOT_BOARD:  host_rsp_o = board_rsp_i;
      SLOT_TIMER:  host_rsp_o = timer_rsp_i;
      default:     host_rsp_o = '{dat: '0, ack: none_ack_q};
    endcase
  end

endmodule

// ==== design/gpio_bank.sv ====
`timescale 1ns/10ps

module gpio_bank (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  deca_pkg::wb_req_t    req_i,
  output deca_pkg::wb_rsp_t    rsp_o,
  input  logic [7:0]           pins_i,
  output deca_pkg::gpio_pins_t pins_o
);

  import deca_pkg::*;

  gpio_reg_e        reg_sel;
  logic             access;
  logic             wr_en;
  logic             ack_q;
  logic [7:0]       dout_q;
  logic [7:0]       dir_q;
  logic [WB_DW-1:0] rd_next;
  logic [WB_DW-1:0] rdata_q;

  assign reg_sel = gpio_reg_e'(req_i.adr[1:0]);
  assign access  = req_i.cyc && req_i.stb && !ack_q;
  // both registers sit in byte lane 0
  assign wr_en   = access && req_i.we && req_i.sel[0];

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      ack_q  <= 1'b0;
      dout_q <= '0;
      dir_q  <= '0;
    end else begin
      ack_q <= access;
      if (wr_en && reg_sel == GPIO_DATA) begin
        dout_q <= req_i.dat[7:0];
      end
      if (wr_en && reg_sel == GPIO_DIR) begin
        dir_q <= req_i.dat[7:0];
      end
    end
  end

  // data offset reads the live pins, not the output register
  always_comb begin
    case (reg_sel)
      GPIO_DATA: rd_next = WB_DW'(pins_i);
      GPIO_DIR:  rd_next = WB_DW'(dir_q);
      default:   rd_next = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (access) begin
      rdata_q <= rd_next;
    end
  end

  assign rsp_o  = '{dat: rdata_q, ack: ack_q};
  assign pins_o = '{dout: dout_q, dir: dir_q};

endmodule

// ==== design/board_io.sv ====
`timescale 1ns/10ps

module board_io #(
  parameter int NUM_SW = 3
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  deca_pkg::wb_req_t req_i,
  output deca_pkg::wb_rsp_t rsp_o,
  input  logic [NUM_SW-1:0] sw_i,
  output logic [7:0]        leds_o,
  output logic              irq_ext_o
);

  import deca_pkg::*;

  board_reg_e        reg_sel;
  logic              access;
  logic              wr_en;
  logic              ack_q;
  logic [7:0]        leds_q;
  logic [NUM_SW-1:0] sw_meta_q;
  logic [NUM_SW-1:0] sw_sync_q;
  logic [NUM_SW-1:0] sw_prev_q;
  logic [NUM_SW-1:0] sw_rise;
  logic [NUM_SW-1:0] pend_clr;
  logic [NUM_SW-1:0] pend_q;
  logic [NUM_SW-1:0] mask_q;
  logic              irq_q;
  logic [WB_DW-1:0]  rd_next;
  logic [WB_DW-1:0]  rdata_q;

  assign reg_sel = board_reg_e'(req_i.adr[1:0]);
  assign access  = req_i.cyc && req_i.stb && !ack_q;
  // up to 8 switches, everything lives in byte lane 0
  assign wr_en   = access && req_i.we && req_i.sel[0];

  assign sw_rise  = sw_sync_q & ~sw_prev_q;
  // write one to clear
  assign pend_clr = (wr_en && reg_sel == BOARD_PEND) ? req_i.dat[NUM_SW-1:0] : '0;

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      ack_q     <= 1'b0;
      leds_q    <= '0;
      sw_meta_q <= '0;
      sw_sync_q <= '0;
      sw_prev_q <= '0;
      pend_q    <= '0;
      mask_q    <= '0;
      irq_q     <= 1'b0;
    end else begin
      ack_q <= access;
      // two flop synchronizer, third flop for the edge
      sw_meta_q <= sw_i;
      sw_sync_q <= sw_meta_q;
      sw_prev_q <= sw_sync_q;
      // new edge wins over a clear in the same cycle
      pend_q <= (pend_q & ~pend_clr) | sw_rise;
      irq_q  <= |(pend_q & mask_q);
      if (wr_en && reg_sel == BOARD_LEDS) begin
        leds_q <= req_i.dat[7:0];
      end
      if (wr_en && reg_sel == BOARD_MASK) begin
        mask_q <= req_i.dat[NUM_SW-1:0];
      end
    end
  end

  always_comb begin
    case (reg_sel)
      BOARD_LEDS: rd_next = WB_DW'(leds_q);
      BOARD_SW:   rd_next = WB_DW'(sw_sync_q);
      BOARD_PEND: rd_next = WB_DW'(pend_q);
      BOARD_MASK: rd_next = WB_DW'(mask_q);
      default:    rd_next = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (access) begin
      rdata_q <= rd_next;
    end
  end

  assign rsp_o     = '{dat: rdata_q, ack: ack_q};
  assign leds_o    = leds_q;
  assign irq_ext_o = irq_q;

endmodule

// ==== design/machine_timer.sv ====
`timescale 1ns/10ps

module machine_timer #(
  parameter int TIMER_DIV = 4
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  deca_pkg::wb_req_t req_i,
  output deca_pkg::wb_rsp_t rsp_o,
  output logic              irq_timer_o
);

  import deca_pkg::*;

  localparam int               DIV_W    = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TIMER_DIV - 1);

  timer_reg_e       reg_sel;
  logic             access;
  logic             wr_en;
  logic             ack_q;
  logic [DIV_W-1:0] div_cnt_q;
  logic             tick;
  logic [63:0]      mtime_q;
  logic [63:0]      mtimecmp_q;
  logic             irq_q;
  logic [WB_DW-1:0] rd_next;
  logic [WB_DW-1:0] rdata_q;

  // replace only the byte lanes enabled by sel
  function automatic logic [WB_DW-1:0] merge_bytes(input logic [WB_DW-1:0] old_v,
                                                   input logic [WB_DW-1:0] new_v,
                                                   input logic [WB_SW-1:0] sel);
    logic [WB_DW-1:0] res;
    res = old_v;
    for (int i = 0; i < WB_SW; i++) begin
      if (sel[i]) begin
        res[i*8 +: 8] = new_v[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign reg_sel = timer_reg_e'(req_i.adr[1:0]);
  assign access  = req_i.cyc && req_i.stb && !ack_q;
  assign wr_en   = access && req_i.we;
  assign tick    = (div_cnt_q == DIV_LAST);

  always_ff @(posedge i_clk or posedge i_rst) begin
    if (i_rst) begin
      ack_q      <= 1'b0;
      div_cnt_q  <= '0;
      mtime_q    <= '0;
      // all ones keeps the interrupt low out of reset
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
    end else begin
      ack_q     <= access;
      div_cnt_q <= tick ? '0 : div_cnt_q + 1'b1;
      // a bus write to mtime takes priority over the tick
      if (wr_en && reg_sel == TIM_LO) begin
        mtime_q[31:0] <= merge_bytes(mtime_q[31:0], req_i.dat, req_i.sel);
      end else if (wr_en && reg_sel == TIM_HI) begin
        mtime_q[63:32] <= merge_bytes(mtime_q[63:32], req_i.dat, req_i.sel);
      end else if (tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_en && reg_sel == CMP_LO) begin
        mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], req_i.dat, req_i.sel);
      end
      if (wr_en && reg_sel == CMP_HI) begin
        mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], req_i.dat, req_i.sel);
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    case (reg_sel)
      TIM_LO:  rd_next = mtime_q[31:0];
      TIM_HI:  rd_next = mtime_q[63:32];
      CMP_LO:  rd_next = mtimecmp_q[31:0];
      default: rd_next = mtimecmp_q[63:32];
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (access) begin
      rdata_q <= rd_next;
    end
  end

  assign rsp_o       = '{dat: rdata_q, ack: ack_q};
  assign irq_timer_o = irq_q;

endmodule

// ==== design/deca_periph_top.sv ====
`timescale 1ns/10ps

module deca_periph_top #(
  parameter int NUM_SW    = 3,
  parameter int TIMER_DIV = 4
) (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  deca_pkg::wb_req_t    wb_req_i,
  output deca_pkg::wb_rsp_t    wb_rsp_o,
  input  logic [7:0]           gpio_a_i,
  input  logic [7:0]           gpio_b_i,
  output deca_pkg::gpio_pins_t gpio_a_o,
  output deca_pkg::gpio_pins_t gpio_b_o,
  input  logic [NUM_SW-1:0]    sw_i,
  output logic [7:0]           leds_o,
  output logic                 irq_ext_o,
  output logic                 irq_timer_o
);

  import deca_pkg::*;

  wb_req_t gpio_a_req;
  wb_req_t gpio_b_req;
  wb_req_t board_req;
  wb_req_t timer_req;
  wb_rsp_t gpio_a_rsp;
  wb_rsp_t gpio_b_rsp;
  wb_rsp_t board_rsp;
  wb_rsp_t timer_rsp;

  wb_decoder wb_decoder_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .host_req_i   (wb_req_i),
    .host_rsp_o   (wb_rsp_o),
    .gpio_a_req_o (gpio_a_req),
    .gpio_b_req_o (gpio_b_req),
    .board_req_o  (board_req),
    .timer_req_o  (timer_req),
    .gpio_a_rsp_i (gpio_a_rsp),
    .gpio_b_rsp_i (gpio_b_rsp),
    .board_rsp_i  (board_rsp),
    .timer_rsp_i  (timer_rsp)
  );

  gpio_bank gpio_a_i_bank (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .req_i  (gpio_a_req),
    .rsp_o  (gpio_a_rsp),
    .pins_i (gpio_a_i),
    .pins_o (gpio_a_o)
  );

  gpio_bank gpio_b_i_bank (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .req_i  (gpio_b_req),
    .rsp_o  (gpio_b_rsp),
    .pins_i (gpio_b_i),
    .pins_o (gpio_b_o)
  );

  board_io #(
    .NUM_SW (NUM_SW)
  ) board_io_i (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .req_i     (board_req),
    .rsp_o     (board_rsp),
    .sw_i      (sw_i),
    .leds_o    (leds_o),
    .irq_ext_o (irq_ext_o)
  );

  machine_timer #(
    .TIMER_DIV (TIMER_DIV)
  ) machine_timer_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .req_i       (timer_req),
    .rsp_o       (timer_rsp),
    .irq_timer_o (irq_timer_o)
  );

endmodule

// ==== testbench/deca_periph_properties.sv ====
`timescale 1ns/10ps

module deca_periph_properties (
  input logic              i_clk,
  input logic              i_rst,
  input deca_pkg::wb_req_t wb_req_i,
  input deca_pkg::wb_rsp_t wb_rsp_i,
  input logic              irq_timer_i
);

  logic req_active;

  assign req_active = wb_req_i.cyc && wb_req_i.stb;

  // one pulse per access
  ack_one_cycle: assert property (
    @(posedge i_clk) disable iff (i_rst) wb_rsp_i.ack |=> !wb_rsp_i.ack
  ) else $error("ack stayed high for more than one cycle");

  // a new ack answers the request seen on the previous edge
  ack_after_req: assert property (
    @(posedge i_clk) disable iff (i_rst) $rose(wb_rsp_i.ack) |-> $past(req_active)
  ) else $error("ack rose without a request on the previous cycle");

  ack_needs_req: assert property (
    @(posedge i_clk) disable iff (i_rst) !req_active |-> !wb_rsp_i.ack
  ) else $error("ack seen while cyc and stb are low");

  // first compare result after reset, compare value resets to all ones
  irq_timer_reset: assert property (
    @(posedge i_clk) $fell(i_rst) |=> !irq_timer_i
  ) else $error("timer interrupt high right after reset");

endmodule

// ==== testbench/tb_deca_periph.sv ====
`timescale 1ns/10ps

module tb_deca_periph;

  import deca_pkg::*;

  localparam int NUM_SW      = 3;
  localparam int TIMER_DIV   = 4;
  localparam int N_GPIO      = 40;
  localparam int N_UNMAPPED  = 8;
  localparam int N_LED       = 8;
  localparam int N_SW        = 6;
  localparam int MARGIN      = 16;
  // bus accesses of all tests and the cycle bound of one access
  localparam int N_ACCESS    = 3 * N_GPIO + N_UNMAPPED + 2 * N_LED + 4 * N_SW + 8;
  localparam int ACCESS_MAX  = 8;
  localparam int CYCLE_LIMIT = N_ACCESS * ACCESS_MAX + N_SW * 16 + MARGIN * TIMER_DIV + 64;

  logic              i_clk;
  logic              i_rst;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp;
  logic [7:0]        pins_in [2];
  gpio_pins_t        pins_out [2];
  logic [NUM_SW-1:0] sw;
  logic [7:0]        leds;
  logic              irq_ext;
  logic              irq_timer;

  integer            seed;
  int                value_errs  = 0;
  int                timing_errs = 0;
  int                cycles      = 0;

  // reference model of the register state
  logic [7:0]        dout_m [2] = '{8'h00, 8'h00};
  logic [7:0]        dir_m [2]  = '{8'h00, 8'h00};
  logic [7:0]        leds_m     = '0;
  logic [NUM_SW-1:0] pend_m     = '0;
  logic [NUM_SW-1:0] mask_m     = '0;

  deca_periph_top #(
    .NUM_SW    (NUM_SW),
    .TIMER_DIV (TIMER_DIV)
  ) deca_periph_top_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .wb_req_i    (wb_req),
    .wb_rsp_o    (wb_rsp),
    .gpio_a_i    (pins_in[0]),
    .gpio_b_i    (pins_in[1]),
    .gpio_a_o    (pins_out[0]),
    .gpio_b_o    (pins_out[1]),
    .sw_i        (sw),
    .leds_o      (leds),
    .irq_ext_o   (irq_ext),
    .irq_timer_o (irq_timer)
  );

  bind deca_periph_top deca_periph_properties deca_periph_properties_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .wb_req_i    (wb_req_i),
    .wb_rsp_i    (wb_rsp_o),
    .irq_timer_i (irq_timer_o)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  // single access, the response is sampled mid-cycle while ack is high
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] sel,
                            output wb_rsp_t rsp);
    int waited;
    @(posedge i_clk);
    wb_req <= '{adr: addr[31:2], dat: wdata, sel: sel, we: wr, cyc: 1'b1, stb: 1'b1};
    waited = 0;
    do begin
      @(negedge i_clk);
      waited++;
    end while (!wb_rsp.ack && waited < ACCESS_MAX);
    rsp = wb_rsp;
    if (!wb_rsp.ack) begin
      timing_errs++;
      $display("no ack for the access to address %h", addr);
    end else if (waited != 2) begin
      timing_errs++;
      $display("[FAIL] ack delay at %h expected 1 actual %0d", addr, waited - 1);
    end
    @(posedge i_clk);
    wb_req <= '0;
  endtask

  task automatic compare_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected dat=%h ack=%b actual dat=%h ack=%b",
               name, exp.dat, exp.ack, act.dat, act.ack);
    end
  endtask

  task automatic verify_pins(input string name, input gpio_pins_t exp, input gpio_pins_t act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected dout=%h dir=%h actual dout=%h dir=%h",
               name, exp.dout, exp.dir, act.dout, act.dir);
    end
  endtask

  task automatic check_leds(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic expect_irq(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
    end
  endtask

  initial begin
    wb_rsp_t     rsp;
    logic [31:0] data;
    logic [31:0] addr;
    logic [3:0]  sel;
    logic [7:0]  pin_val;
    logic [63:0] target;
    int          bank;
    int          sw_idx;
    seed       = 32'h887e4dcf;
    i_rst      = 1'b1;
    wb_req     = '0;
    pins_in[0] = '0;
    pins_in[1] = '0;
    sw         = '0;
    repeat (4) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);

    // reset values
    verify_pins("reset gpio a", '{dout: dout_m[0], dir: dir_m[0]}, pins_out[0]);
    verify_pins("reset gpio b", '{dout: dout_m[1], dir: dir_m[1]}, pins_out[1]);
    check_leds("reset leds", leds_m, leds);
    expect_irq("reset irq_ext", 1'b0, irq_ext);
    expect_irq("reset irq_timer", 1'b0, irq_timer);

    // gpio writes, dir readback and pin readback
    for (int n = 0; n < N_GPIO; n++) begin
      bank = {$random(seed)} % 2;
      addr = 32'(bank * 16 + ({$random(seed)} % 2) * 4);
      data = $random(seed);
      sel  = 4'($random(seed));
      bus_access(1'b1, addr, data, sel, rsp);
      if (sel[0] && addr[2]) begin
        dir_m[bank] = data[7:0];
      end else if (sel[0]) begin
        dout_m[bank] = data[7:0];
      end
      @(negedge i_clk);
      verify_pins("gpio a pins", '{dout: dout_m[0], dir: dir_m[0]}, pins_out[0]);
      verify_pins("gpio b pins", '{dout: dout_m[1], dir: dir_m[1]}, pins_out[1]);
      bus_access(1'b0, 32'(bank * 16 + 4), '0, 4'hf, rsp);
      compare_rsp("gpio dir read", '{dat: 32'(dir_m[bank]), ack: 1'b1}, rsp);
      pin_val = 8'($random(seed));
      @(posedge i_clk);
      pins_in[bank] <= pin_val;
      bus_access(1'b0, 32'(bank * 16), '0, 4'hf, rsp);
      compare_rsp("gpio data read", '{dat: 32'(pin_val), ack: 1'b1}, rsp);
    end

    // slots 4 to 15 answer with zero
    for (int n = 0; n < N_UNMAPPED; n++) begin
      addr = {24'h0, 4'(4 + {$random(seed)} % 12), 2'($random(seed)), 2'b00};
      bus_access(1'b0, addr, '0, 4'hf, rsp);
      compare_rsp("unmapped read", '{dat: '0, ack: 1'b1}, rsp);
    end

    for (int n = 0; n < N_LED; n++) begin
      data = $random(seed);
      sel  = 4'($random(seed));
      bus_access(1'b1, 32'h20, data, sel, rsp);
      if (sel[0]) begin
        leds_m = data[7:0];
      end
      @(negedge i_clk);
      check_leds("leds", leds_m, leds);
      bus_access(1'b0, 32'h20, '0, 4'hf, rsp);
      compare_rsp("leds read", '{dat: 32'(leds_m), ack: 1'b1}, rsp);
    end

    // switch edge sets pending, irq follows pending and mask
    for (int n = 0; n < N_SW; n++) begin
      data = $random(seed);
      bus_access(1'b1, 32'h2c, data, 4'h1, rsp);
      mask_m = data[NUM_SW-1:0];
      sw_idx = {$random(seed)} % NUM_SW;
      @(posedge i_clk);
      sw[sw_idx] <= 1'b1;
      pend_m[sw_idx] = 1'b1;
      repeat (6) @(posedge i_clk);
      @(negedge i_clk);
      expect_irq("irq_ext after edge", |(pend_m & mask_m), irq_ext);
      bus_access(1'b0, 32'h28, '0, 4'hf, rsp);
      compare_rsp("pending after edge", '{dat: 32'(pend_m), ack: 1'b1}, rsp);
      bus_access(1'b1, 32'h28, 32'd1 << sw_idx, 4'h1, rsp);
      pend_m[sw_idx] = 1'b0;
      @(negedge i_clk);
      expect_irq("irq_ext after clear", |(pend_m & mask_m), irq_ext);
      bus_access(1'b0, 32'h28, '0, 4'hf, rsp);
      compare_rsp("pending after clear", '{dat: 32'(pend_m), ack: 1'b1}, rsp);
      @(posedge i_clk);
      sw[sw_idx] <= 1'b0;
      repeat (4) @(posedge i_clk);
    end

    // timer compare a few ticks ahead of mtime
    bus_access(1'b0, 32'h30, '0, 4'hf, rsp);
    target[31:0] = rsp.dat;
    bus_access(1'b0, 32'h34, '0, 4'hf, rsp);
    target[63:32] = rsp.dat;
    target = target + 64'(MARGIN);
    bus_access(1'b1, 32'h38, target[31:0], 4'hf, rsp);
    bus_access(1'b1, 32'h3c, target[63:32], 4'hf, rsp);
    @(negedge i_clk);
    expect_irq("irq_timer before compare", 1'b0, irq_timer);
    bus_access(1'b0, 32'h38, '0, 4'hf, rsp);
    compare_rsp("mtimecmp low read", '{dat: target[31:0], ack: 1'b1}, rsp);
    repeat (MARGIN * TIMER_DIV + 4) @(posedge i_clk);
    @(negedge i_clk);
    expect_irq("irq_timer after compare", 1'b1, irq_timer);
    bus_access(1'b1, 32'h38, 32'hffff_ffff, 4'hf, rsp);
    bus_access(1'b1, 32'h3c, 32'hffff_ffff, 4'hf, rsp);
    @(negedge i_clk);
    expect_irq("irq_timer after rearm", 1'b0, irq_timer);

    $display("value errors %0d, timing errors %0d", value_errs, timing_errs);
    if (value_errs + timing_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/deca_pkg.sv
design/wb_decoder.sv
design/gpio_bank.sv
design/board_io.sv
design/machine_timer.sv
design/deca_periph_top.sv
testbench/deca_periph_properties.sv
testbench/tb_deca_periph.sv

// ==== Bender.yml ====
package:
  name: deca_periph

sources:
  - files:
      - design/deca_pkg.sv
      - design/wb_decoder.sv
      - design/gpio_bank.sv
      - design/board_io.sv
      - design/machine_timer.sv
      - design/deca_periph_top.sv
  - target: test
    files:
      - testbench/deca_periph_properties.sv
      - testbench/tb_deca_periph.sv
